// File: Bender.yml
package:
  name: load_unit

sources:
  - files:
      - ld_pkg.sv
      - ld_buf_if.sv
      - ld_buffer.sv
      - ld_req_ctrl.sv
      - ld_result_align.sv
      - load_unit_top.sv
  - target: test
    files:
      - tb_load_checker.sv
      - tb_load_unit_assert.sv
      - tb_load_unit.sv

// File: build.f
ld_pkg.sv
ld_buf_if.sv
ld_buffer.sv
ld_req_ctrl.sv
ld_result_align.sv
load_unit_top.sv
tb_load_checker.sv
tb_load_unit_assert.sv
tb_load_unit.sv

// File: ld_buf_if.sv
// Load buffer access interface
`default_nettype none

interface ld_buf_if
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
) ();

  // Slot index width
  localparam int unsigned ID_BITS = $clog2(NR_LDBUF);

  // Write port, one new outstanding load
  logic               w_en;
  logic [ID_BITS-1:0] w_id;
  trans_id_t          w_trans_id;
  ld_op_e             w_op;
  offset_t            w_offset;

  // Occupancy
  logic               full;
  logic [ID_BITS-1:0] free_id;

  // Read port, slot addressed by the response ID
  logic               r_en;
  logic [ID_BITS-1:0] r_id;
  trans_id_t          r_trans_id;
  ld_op_e             r_op;
  offset_t            r_offset;
  logic               r_flushed;

  modport req (
    output w_en, w_id, w_trans_id, w_op, w_offset,
    input  full, free_id
  );

  modport rsp (
    output r_en, r_id,
    input  r_trans_id, r_op, r_offset, r_flushed
  );

  modport ldbuf (
    input  w_en, w_id, w_trans_id, w_op, w_offset, r_en, r_id,
    output full, free_id, r_trans_id, r_op, r_offset, r_flushed
  );

endinterface

`default_nettype wire

// File: ld_buffer.sv
// Outstanding load buffer
`default_nettype none

module ld_buffer
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
) (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   flush_i,
  ld_buf_if.ldbuf     buf_o
);

  localparam int unsigned ID_BITS = $clog2(NR_LDBUF);

  typedef logic [ID_BITS-1:0] slot_id_t;

  // Slot state flags
  logic [NR_LDBUF-1:0] valid_q, valid_d;
  logic [NR_LDBUF-1:0] flushed_q, flushed_d;

  // Slot payload
  trans_id_t trans_id_q [NR_LDBUF];
  ld_op_e    op_q       [NR_LDBUF];
  offset_t   offset_q   [NR_LDBUF];

  // ------------------------------------------------------------
  // Free slot search
  // ------------------------------------------------------------
  // Walk down so the lowest free index wins
  always_comb begin : free_search
    buf_o.free_id = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        buf_o.free_id = slot_id_t'(i);
      end
    end
  end

  // Full once every slot holds a load
  assign buf_o.full = &valid_q;

  // ------------------------------------------------------------
  // Flag update
  // ------------------------------------------------------------
  always_comb begin : flag_next
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // Flush marks every slot, in flight or not
    if (flush_i) begin
      flushed_d = '1;
    end
    // Response retires its slot
    if (buf_o.r_en) begin
      valid_d[buf_o.r_id] = 1'b0;
    end
    // New load starts clean even in a flush cycle
    if (buf_o.w_en) begin
      valid_d[buf_o.w_id]   = 1'b1;
      flushed_d[buf_o.w_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : flag_regs
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  // ------------------------------------------------------------
  // Payload storage
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin : payload_regs
    if (buf_o.w_en) begin
      trans_id_q[buf_o.w_id] <= buf_o.w_trans_id;
      op_q[buf_o.w_id]       <= buf_o.w_op;
      offset_q[buf_o.w_id]   <= buf_o.w_offset;
    end
  end

  // Read side, addressed by the response ID
  assign buf_o.r_trans_id = trans_id_q[buf_o.r_id];
  assign buf_o.r_op       = op_q[buf_o.r_id];
  assign buf_o.r_offset   = offset_q[buf_o.r_id];
  assign buf_o.r_flushed  = flushed_q[buf_o.r_id];

endmodule

`default_nettype wire

// File: ld_pkg.sv
// Load unit shared definitions
`default_nettype none

package ld_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  // Data word width
  localparam int unsigned XLEN = 64;
  // Physical address width, equal to the virtual one without MMU
  localparam int unsigned PLEN = 32;
  // Scoreboard transaction ID width
  localparam int unsigned TRANS_ID_BITS = 3;
  // Byte offset inside one data word
  localparam int unsigned OFFS_BITS = 3;

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------
  typedef logic [XLEN-1:0] data_t;
  typedef logic [PLEN-1:0] paddr_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [XLEN/8-1:0] be_t;
  typedef logic [OFFS_BITS-1:0] offset_t;

  // Supported integer loads
  typedef enum logic [2:0] {
    LD  = 3'd0,
    LW  = 3'd1,
    LWU = 3'd2,
    LH  = 3'd3,
    LHU = 3'd4,
    LB  = 3'd5,
    LBU = 3'd6
  } ld_op_e;

  // Request side state, pass-through or held while the grant is missing
  typedef enum logic {
    TRANSPARENT = 1'b0,
    REGISTERED  = 1'b1
  } ld_state_e;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // Access size in bytes
  function automatic logic [3:0] ld_size_bytes(ld_op_e op);
    logic [3:0] size;
    case (op)
      LD:       size = 4'd8;
      LW, LWU:  size = 4'd4;
      LH, LHU:  size = 4'd2;
      default:  size = 4'd1;
    endcase
    return size;
  endfunction

  // Sign-extending loads
  function automatic logic ld_is_signed(ld_op_e op);
    return (op == LW) || (op == LH) || (op == LB);
  endfunction

endpackage

`default_nettype wire

// File: ld_req_ctrl.sv
// Load request control
`default_nettype none

module ld_req_ctrl
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4,
  localparam int unsigned ID_BITS = $clog2(NR_LDBUF)
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               flush_i,
  // Load from the issue side
  input  wire logic               valid_i,
  input  wire paddr_t             vaddr_i,
  input  wire trans_id_t          trans_id_i,
  input  wire ld_op_e             op_i,
  output logic                    pop_ld_o,
  // Memory request channel
  output logic                    preq_o,
  output paddr_t                  paddr_o,
  output be_t                     be_o,
  output logic [ID_BITS-1:0]      aid_o,
  input  wire logic               pgnt_i,
  // Buffer write side
  ld_buf_if.req                   buf_o
);

  ld_state_e state_q, state_d;

  // Held request while the grant is missing
  paddr_t             paddr_q;
  be_t                be_q;
  logic [ID_BITS-1:0] aid_q;

  logic    accept;
  offset_t offset;
  be_t     size_mask;
  be_t     be;

  // ------------------------------------------------------------
  // Acceptance and buffer write
  // ------------------------------------------------------------
  // Back-pressure while a request is held, buffer full or flushing
  assign accept = valid_i && (state_q == TRANSPARENT) && !buf_o.full && !flush_i;
  assign pop_ld_o = accept;

  assign offset = vaddr_i[OFFS_BITS-1:0];

  assign buf_o.w_en       = accept;
  assign buf_o.w_id       = buf_o.free_id;
  assign buf_o.w_trans_id = trans_id_i;
  assign buf_o.w_op       = op_i;
  assign buf_o.w_offset   = offset;

  // Size mask placed at the byte offset
  assign size_mask = be_t'((9'd1 << ld_size_bytes(op_i)) - 9'd1);
  assign be        = size_mask << offset;

  // ------------------------------------------------------------
  // Request FSM
  // ------------------------------------------------------------
  always_comb begin : req_fsm
    state_d = state_q;
    preq_o  = 1'b0;
    case (state_q)
      TRANSPARENT: begin
        preq_o = accept;
        // No grant, keep the request alive from the registers
        if (accept && !pgnt_i) begin
          state_d = REGISTERED;
        end
      end
      REGISTERED: begin
        preq_o = 1'b1;
        if (pgnt_i) begin
          state_d = TRANSPARENT;
        end
      end
      default: begin
        state_d = TRANSPARENT;
      end
    endcase
  end

  // Live values pass through, held values once registered
  assign paddr_o = (state_q == TRANSPARENT) ? vaddr_i : paddr_q;
  assign be_o    = (state_q == TRANSPARENT) ? be : be_q;
  assign aid_o   = (state_q == TRANSPARENT) ? buf_o.free_id : aid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= TRANSPARENT;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture every transparent cycle, freeze while registered
  always_ff @(posedge clk_i) begin : hold_regs
    if (state_q == TRANSPARENT) begin
      paddr_q <= vaddr_i;
      be_q    <= be;
      aid_q   <= buf_o.free_id;
    end
  end

endmodule

`default_nettype wire

// File: ld_result_align.sv
// Load result alignment
`default_nettype none

module ld_result_align
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4,
  localparam int unsigned ID_BITS = $clog2(NR_LDBUF)
) (
  // Memory response channel
  input  wire logic               rvalid_i,
  input  wire logic [ID_BITS-1:0] rid_i,
  input  wire data_t              rdata_i,
  // Writeback to the issue side
  output logic                    valid_o,
  output trans_id_t               trans_id_o,
  output data_t                   result_o,
  // Buffer read side
  ld_buf_if.rsp                   buf_o
);

  data_t shifted;
  logic  is_signed;
  logic  sign_bit;

  // ------------------------------------------------------------
  // Response matching
  // ------------------------------------------------------------
  // Response ID selects the slot, which is freed at the next edge
  assign buf_o.r_en = rvalid_i;
  assign buf_o.r_id = rid_i;

  // Cancelled loads are dropped silently
  assign valid_o    = rvalid_i && !buf_o.r_flushed;
  assign trans_id_o = buf_o.r_trans_id;

  // ------------------------------------------------------------
  // Realign and extend
  // ------------------------------------------------------------
  // Bring the addressed byte down to bit 0
  assign shifted   = rdata_i >> {buf_o.r_offset, 3'b000};
  assign is_signed = ld_is_signed(buf_o.r_op);

  always_comb begin : extend
    sign_bit = 1'b0;
    result_o = shifted;
    case (buf_o.r_op)
      LW, LWU: begin
        sign_bit = is_signed & shifted[31];
        result_o = {{(XLEN - 32){sign_bit}}, shifted[31:0]};
      end
      LH, LHU: begin
        sign_bit = is_signed & shifted[15];
        result_o = {{(XLEN - 16){sign_bit}}, shifted[15:0]};
      end
      LB, LBU: begin
        sign_bit = is_signed & shifted[7];
        result_o = {{(XLEN - 8){sign_bit}}, shifted[7:0]};
      end
      // Full doubleword, nothing to extend
      default: begin
        result_o = shifted;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: load_unit_top.sv
// Load unit top level
`default_nettype none

module load_unit_top
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4,
  localparam int unsigned ID_BITS = $clog2(NR_LDBUF)
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               flush_i,
  // Load from the issue side
  input  wire logic               valid_i,
  input  wire paddr_t             vaddr_i,
  input  wire trans_id_t          trans_id_i,
  input  wire ld_op_e             op_i,
  output logic                    pop_ld_o,
  // Memory request channel
  output logic                    preq_o,
  output paddr_t                  paddr_o,
  output be_t                     be_o,
  output logic [ID_BITS-1:0]      aid_o,
  input  wire logic               pgnt_i,
  // Memory response channel
  input  wire logic               rvalid_i,
  input  wire logic [ID_BITS-1:0] rid_i,
  input  wire data_t              rdata_i,
  // Writeback
  output logic                    valid_o,
  output trans_id_t               trans_id_o,
  output data_t                   result_o
);

  // Shared slot bus between request, response and buffer
  ld_buf_if #(.NR_LDBUF(NR_LDBUF)) ld_buf_bus ();

  ld_buffer #(.NR_LDBUF(NR_LDBUF)) ld_buffer_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .buf_o   (ld_buf_bus)
  );

  ld_req_ctrl #(.NR_LDBUF(NR_LDBUF)) ld_req_ctrl_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .valid_i    (valid_i),
    .vaddr_i    (vaddr_i),
    .trans_id_i (trans_id_i),
    .op_i       (op_i),
    .pop_ld_o   (pop_ld_o),
    .preq_o     (preq_o),
    .paddr_o    (paddr_o),
    .be_o       (be_o),
    .aid_o      (aid_o),
    .pgnt_i     (pgnt_i),
    .buf_o      (ld_buf_bus)
  );

  ld_result_align #(.NR_LDBUF(NR_LDBUF)) ld_result_align_i (
    .rvalid_i   (rvalid_i),
    .rid_i      (rid_i),
    .rdata_i    (rdata_i),
    .valid_o    (valid_o),
    .trans_id_o (trans_id_o),
    .result_o   (result_o),
    .buf_o      (ld_buf_bus)
  );

endmodule

`default_nettype wire

// File: tb_load_checker.sv
// Load unit result checker
`default_nettype none

module tb_load_checker
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4,
  localparam int unsigned ID_BITS = $clog2(NR_LDBUF)
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               flush_i,
  // Issue side
  input  wire logic               valid_i,
  input  wire paddr_t             vaddr_i,
  input  wire trans_id_t          trans_id_i,
  input  wire ld_op_e             op_i,
  input  wire logic               pop_i,
  // Memory request and response
  input  wire logic               preq_i,
  input  wire paddr_t             paddr_i,
  input  wire be_t                be_i,
  input  wire logic [ID_BITS-1:0] aid_i,
  input  wire logic               pgnt_i,
  input  wire logic               rvalid_i,
  input  wire logic [ID_BITS-1:0] rid_i,
  input  wire data_t              rdata_i,
  // Writeback
  input  wire logic               res_valid_i,
  input  wire trans_id_t          res_trans_id_i,
  input  wire data_t              result_i,
  // Counters for the testbench top
  output int                      errors_o,
  output int                      checks_o,
  output int                      pending_o
);

  int errors = 0;
  int checks = 0;
  int open_loads = 0;

  // Accepted loads still waiting for their grant, in order
  trans_id_t acc_tid     [$];
  ld_op_e    acc_op      [$];
  offset_t   acc_offs    [$];
  paddr_t    acc_addr    [$];
  bit        acc_flushed [$];

  // Granted loads, indexed by the slot ID seen on aid_o
  bit        slot_busy    [NR_LDBUF];
  bit        slot_flushed [NR_LDBUF];
  trans_id_t slot_tid     [NR_LDBUF];
  ld_op_e    slot_op      [NR_LDBUF];
  offset_t   slot_offs    [NR_LDBUF];

  // Set by the first load after reset
  bit seen_load;

  assign errors_o  = errors;
  assign checks_o  = checks;
  assign pending_o = open_loads;

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic int access_bytes(ld_op_e op);
    case (op)
      LD:      return 8;
      LW, LWU: return 4;
      LH, LHU: return 2;
      default: return 1;
    endcase
  endfunction

  // One enable per loaded byte, starting at the offset
  function automatic be_t mask_for_access(ld_op_e op, offset_t offs);
    be_t mask;
    mask = be_t'((1 << access_bytes(op)) - 1);
    return mask << offs;
  endfunction

  // Field at the byte offset, extended by op
  function automatic data_t load_reference(ld_op_e op, offset_t offs, data_t rdata);
    data_t field;
    field = rdata >> (8 * offs);
    case (op)
      LW:      return {{32{field[31]}}, field[31:0]};
      LWU:     return {32'b0, field[31:0]};
      LH:      return {{48{field[15]}}, field[15:0]};
      LHU:     return {48'b0, field[15:0]};
      LB:      return {{56{field[7]}}, field[7:0]};
      LBU:     return {56'b0, field[7:0]};
      default: return field;
    endcase
  endfunction

  task automatic show_mismatch(input string name, input data_t got, input data_t exp);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic flag_failure(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  // ------------------------------------------------------------
  // Compare at each rising edge, on the values before the edge
  // ------------------------------------------------------------
  always @(posedge clk_i) begin : watch
    int    occupied;
    data_t expected;
    if (!rst_ni) begin
      acc_tid.delete();
      acc_op.delete();
      acc_offs.delete();
      acc_addr.delete();
      acc_flushed.delete();
      for (int i = 0; i < NR_LDBUF; i++) begin
        slot_busy[i]    = 1'b0;
        slot_flushed[i] = 1'b0;
      end
      seen_load  = 1'b0;
      open_loads = 0;
    end else begin
      occupied = acc_tid.size();
      for (int i = 0; i < NR_LDBUF; i++) begin
        occupied += slot_busy[i];
      end
      // Quiet outputs until the first load
      if (valid_i) begin
        seen_load = 1'b1;
      end else if (!seen_load && (pop_i || preq_i || res_valid_i)) begin
        flag_failure("output active after reset before the first load");
      end
      // Accepted load joins the grant queue
      if (pop_i) begin
        if (acc_tid.size() != 0) begin
          flag_failure("load popped while a request waits for its grant");
        end
        if (occupied >= NR_LDBUF) begin
          flag_failure("load popped with every slot busy");
        end
        acc_tid.push_back(trans_id_i);
        acc_op.push_back(op_i);
        acc_offs.push_back(vaddr_i[OFFS_BITS-1:0]);
        acc_addr.push_back(vaddr_i);
        acc_flushed.push_back(1'b0);
      end
      // Grant pairs the oldest accepted load with its slot
      if (preq_i && pgnt_i) begin
        if (acc_tid.size() == 0) begin
          flag_failure("grant seen with no accepted load");
        end else begin
          checks++;
          if (paddr_i !== acc_addr[0]) begin
            show_mismatch("paddr_o", data_t'(paddr_i), data_t'(acc_addr[0]));
          end
          if (be_i !== mask_for_access(acc_op[0], acc_offs[0])) begin
            show_mismatch("be_o", data_t'(be_i),
                          data_t'(mask_for_access(acc_op[0], acc_offs[0])));
          end
          if (slot_busy[aid_i]) begin
            flag_failure("grant names a slot that is still busy");
          end
          slot_busy[aid_i]    = 1'b1;
          slot_tid[aid_i]     = acc_tid.pop_front();
          slot_op[aid_i]      = acc_op.pop_front();
          slot_offs[aid_i]    = acc_offs.pop_front();
          slot_flushed[aid_i] = acc_flushed.pop_front();
          void'(acc_addr.pop_front());
        end
      end
      // Response retires its slot
      if (rvalid_i) begin
        if (!slot_busy[rid_i]) begin
          flag_failure("response for a slot with no load");
        end else begin
          checks++;
          if (slot_flushed[rid_i]) begin
            // Cancelled load must stay silent
            if (res_valid_i !== 1'b0) begin
              show_mismatch("valid_o", data_t'(res_valid_i), 64'd0);
            end
          end else begin
            expected = load_reference(slot_op[rid_i], slot_offs[rid_i], rdata_i);
            if (res_valid_i !== 1'b1) begin
              show_mismatch("valid_o", data_t'(res_valid_i), 64'd1);
            end
            if (res_trans_id_i !== slot_tid[rid_i]) begin
              show_mismatch("trans_id_o", data_t'(res_trans_id_i), data_t'(slot_tid[rid_i]));
            end
            if (result_i !== expected) begin
              show_mismatch("result_o", result_i, expected);
            end
          end
          slot_busy[rid_i] = 1'b0;
        end
      end else if (res_valid_i) begin
        flag_failure("valid_o raised without a response");
      end
      // Flush cancels everything accepted so far
      if (flush_i) begin
        foreach (acc_flushed[i]) begin
          acc_flushed[i] = 1'b1;
        end
        for (int i = 0; i < NR_LDBUF; i++) begin
          slot_flushed[i] = 1'b1;
        end
      end
      open_loads = acc_tid.size();
      for (int i = 0; i < NR_LDBUF; i++) begin
        open_loads += slot_busy[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_load_unit.sv
// Load unit testbench
`default_nettype none

module tb_load_unit
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
);

  localparam int unsigned ID_BITS = $clog2(NR_LDBUF);

  // Loads per test, used for the cycle limit
  localparam int unsigned SWEEP_LOADS  = 29;
  localparam int unsigned HOLD_LOADS   = 4;
  localparam int unsigned FULL_LOADS   = NR_LDBUF + 2;
  localparam int unsigned FLUSH_LOADS  = NR_LDBUF + 6;
  localparam int unsigned RANDOM_LOADS = 100;
  localparam int unsigned TOTAL_LOADS  = SWEEP_LOADS + HOLD_LOADS + FULL_LOADS
                                         + FLUSH_LOADS + RANDOM_LOADS;
  localparam int unsigned MAX_CYCLES   = 20 * TOTAL_LOADS + 200;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               flush_i;
  logic               valid_i;
  paddr_t             vaddr_i;
  trans_id_t          trans_id_i;
  ld_op_e             op_i;
  logic               pop_ld_o;
  logic               preq_o;
  paddr_t             paddr_o;
  be_t                be_o;
  logic [ID_BITS-1:0] aid_o;
  logic               pgnt_i;
  logic               rvalid_i;
  logic [ID_BITS-1:0] rid_i;
  data_t              rdata_i;
  logic               valid_o;
  trans_id_t          trans_id_o;
  data_t              result_o;

  // Memory model controls and granted slots
  logic               hold_gnt;
  logic               resp_en;
  logic [ID_BITS-1:0] granted [$];

  int        cycles = 0;
  int        errors, checks, pending;
  int        tests_run = 0;
  int        tests_failed = 0;
  int        errors_before = 0;
  trans_id_t next_tid;

  always #20 clk_i = ~clk_i;

  load_unit_top #(.NR_LDBUF(NR_LDBUF)) load_unit_top_i (.*);

  tb_load_checker #(.NR_LDBUF(NR_LDBUF)) load_checker_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .valid_i        (valid_i),
    .vaddr_i        (vaddr_i),
    .trans_id_i     (trans_id_i),
    .op_i           (op_i),
    .pop_i          (pop_ld_o),
    .preq_i         (preq_o),
    .paddr_i        (paddr_o),
    .be_i           (be_o),
    .aid_i          (aid_o),
    .pgnt_i         (pgnt_i),
    .rvalid_i       (rvalid_i),
    .rid_i          (rid_i),
    .rdata_i        (rdata_i),
    .res_valid_i    (valid_o),
    .res_trans_id_i (trans_id_o),
    .result_i       (result_o),
    .errors_o       (errors),
    .checks_o       (checks),
    .pending_o      (pending)
  );

  // ------------------------------------------------------------
  // Memory model
  // ------------------------------------------------------------
  // Remember each granted slot
  always @(posedge clk_i) begin : mem_capture
    if (!rst_ni) begin
      granted.delete();
    end else if (preq_o && pgnt_i) begin
      granted.push_back(aid_o);
    end
  end

  // Random grant, responses in random order with random data
  always @(negedge clk_i) begin : mem_drive
    int idx;
    pgnt_i   = !hold_gnt && ($urandom % 4 != 0);
    rvalid_i = 1'b0;
    if (rst_ni && resp_en && granted.size() != 0 && ($urandom % 3 == 0)) begin
      idx = $urandom % granted.size();
      rid_i = granted[idx];
      granted.delete(idx);
      rdata_i  = {$urandom, $urandom};
      rvalid_i = 1'b1;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d loads still open", cycles, pending);
      $display("tests failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers, all start and end on a falling edge
  // ------------------------------------------------------------
  // Present one load and hold it until the DUT pops it
  task automatic issue_load(input ld_op_e op, input offset_t offs);
    paddr_t addr;
    logic   popped;
    addr = paddr_t'($urandom);
    addr[OFFS_BITS-1:0] = offs;
    valid_i    = 1'b1;
    vaddr_i    = addr;
    op_i       = op;
    trans_id_i = next_tid;
    popped     = 1'b0;
    while (!popped) begin
      @(posedge clk_i);
      popped = pop_ld_o;
      @(negedge clk_i);
    end
    valid_i = 1'b0;
    next_tid++;
  endtask

  // Random op at an offset aligned to its size
  task automatic send_random_load();
    ld_op_e op;
    int     size;
    op   = ld_op_e'($urandom % 7);
    size = ld_size_bytes(op);
    issue_load(op, offset_t'(($urandom % (8 / size)) * size));
  endtask

  task automatic drain_loads();
    while (pending != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic test_summary(input string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    ld_op_e op;
    int     gap;
    int     assert_fails;
    void'($urandom(32'h5c06));
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    valid_i    = 1'b0;
    vaddr_i    = '0;
    trans_id_i = '0;
    op_i       = LD;
    pgnt_i     = 1'b0;
    rvalid_i   = 1'b0;
    rid_i      = '0;
    rdata_i    = '0;
    hold_gnt   = 1'b0;
    resp_en    = 1'b1;
    next_tid   = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    // Outputs stay low with no load presented
    repeat (4) @(negedge clk_i);
    test_summary("idle after reset");

    for (int o = 0; o < 7; o++) begin
      op = ld_op_e'(o);
      for (int offs = 0; offs < 8; offs += ld_size_bytes(op)) begin
        issue_load(op, offset_t'(offs));
      end
    end
    drain_loads();
    test_summary("op and offset sweep");

    // Grant withheld, second load must wait
    for (int r = 0; r < 2; r++) begin
      drain_loads();
      @(posedge clk_i);
      hold_gnt = 1'b1;
      @(negedge clk_i);
      issue_load(LW, 3'd4);
      fork
        issue_load(LD, 3'd0);
        begin
          repeat (6) @(posedge clk_i);
          hold_gnt = 1'b0;
        end
      join
    end
    drain_loads();
    test_summary("grant held low");

    // Fill every slot with responses off
    @(posedge clk_i);
    resp_en = 1'b0;
    @(negedge clk_i);
    repeat (NR_LDBUF) send_random_load();
    fork
      begin
        send_random_load();
        send_random_load();
      end
      begin
        repeat (8) @(posedge clk_i);
        resp_en = 1'b1;
      end
    join
    drain_loads();
    test_summary("buffer full and out of order");

    // Flush with every slot in flight
    @(posedge clk_i);
    resp_en = 1'b0;
    @(negedge clk_i);
    repeat (NR_LDBUF) send_random_load();
    pulse_flush();
    @(posedge clk_i);
    resp_en = 1'b1;
    @(negedge clk_i);
    repeat (6) send_random_load();
    drain_loads();
    test_summary("flush");

    for (int n = 0; n < RANDOM_LOADS; n++) begin
      if ($urandom % 20 == 0) begin
        pulse_flush();
      end
      gap = $urandom % 3;
      repeat (gap) @(negedge clk_i);
      send_random_load();
    end
    drain_loads();
    test_summary("random traffic");

    assert_fails = load_unit_top_i.load_unit_assert_i.fail_count;
    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, errors, assert_fails);
    if (tests_failed == 0 && assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_load_unit_assert.sv
// Load unit protocol assertions
`default_nettype none

module tb_load_unit_assert
  import ld_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4,
  localparam int unsigned ID_BITS = $clog2(NR_LDBUF)
) (
  input wire logic               clk_i,
  input wire logic               rst_ni,
  input wire logic               flush_i,
  input wire logic               valid_i,
  input wire logic               pop_i,
  input wire logic               preq_i,
  input wire paddr_t             paddr_i,
  input wire be_t                be_i,
  input wire logic [ID_BITS-1:0] aid_i,
  input wire logic               pgnt_i,
  input wire logic               rvalid_i,
  input wire logic               res_valid_i
);

  // Failures seen so far for the end-of-run report
  int fail_count = 0;

  // Request keeps address, byte enables and slot until granted
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    preq_i && !pgnt_i |=> preq_i && $stable(paddr_i) && $stable(be_i) && $stable(aid_i))
    else begin
      fail_count++;
      $error("request dropped or changed before its grant");
    end

  // Writeback only in a response cycle
  // A response right after a flush belongs to a cancelled load
  valid_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> rvalid_i && !$past(flush_i))
    else begin
      fail_count++;
      $error("valid_o without rvalid_i or for a cancelled load");
    end

  // Pop only for a presented load and never while a request waits for its grant
  pop_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_i && !$past(preq_i && !pgnt_i))
    else begin
      fail_count++;
      $error("pop_ld_o without valid_i or while a request waits for its grant");
    end

endmodule

bind load_unit_top tb_load_unit_assert #(.NR_LDBUF(NR_LDBUF)) load_unit_assert_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .valid_i     (valid_i),
  .pop_i       (pop_ld_o),
  .preq_i      (preq_o),
  .paddr_i     (paddr_o),
  .be_i        (be_o),
  .aid_i       (aid_o),
  .pgnt_i      (pgnt_i),
  .rvalid_i    (rvalid_i),
  .res_valid_i (valid_o)
);

`default_nettype wire
